/* verilog/rtg_pkg.sv */
`default_nettype none

package rtg_pkg;

  ////////////////////////////////////////////////////////////
  // Sizes
  ////////////////////////////////////////////////////////////
  localparam int FRAME_ADDR_W = 12;                  // Frame memory word address
  localparam int FRAME_DEPTH  = 1 << FRAME_ADDR_W;   // Words in frame memory
  localparam int WORD_W       = 16;                  // Frame word
  localparam int COLOR_W      = 8;                   // Per channel
  localparam int FIFO_DEPTH   = 16;                  // Stream FIFO words
  localparam int FIFO_AW      = $clog2(FIFO_DEPTH);
  localparam int CNT_W        = FIFO_AW + 1;         // Holds 0..FIFO_DEPTH
  localparam int BURST_LEN    = 8;                   // Words per fetch burst
  localparam int CLUT_DEPTH   = 256;
  localparam int CLUT_IDX_W   = $clog2(CLUT_DEPTH);
  localparam int PIX_CNT_W    = 3;                   // Clocks per fetch counter
  localparam int VB_CNT_W     = 5;                   // Extra blank lines
  localparam int BASE_ALIGN   = 4;                   // Low zero bits of base

  ////////////////////////////////////////////////////////////
  // Types
  ////////////////////////////////////////////////////////////
  typedef struct packed {
    logic [COLOR_W-1:0] r;
    logic [COLOR_W-1:0] g;
    logic [COLOR_W-1:0] b;
  } rgb_t;

  typedef struct packed {
    logic [4:0] red;
    logic [5:0] green;
    logic [4:0] blue;
  } rgb565_t;

  typedef struct packed {
    logic [CLUT_IDX_W-1:0] hi_idx;                   // Second pixel
    logic [CLUT_IDX_W-1:0] lo_idx;                   // First pixel
  } clut_pair_t;

  // One frame word, read as hi-colour or as two palette indices
  typedef union packed {
    rgb565_t    rgb565;
    clut_pair_t clut;
  } frame_word_u;

  typedef struct packed {
    logic                           ena;             // RTG screen on
    logic                           clut_mode;       // 8-bit indexed
    logic                           ext;             // Active area one clock longer
    logic [PIX_CNT_W-1:0]           pixel_width;     // Clocks per fetch minus one
    logic [VB_CNT_W-1:0]            vb_end;          // Extra blank lines
    logic [FRAME_ADDR_W-BASE_ALIGN-1:0] base_addr;   // Above alignment bits
  } rtg_cfg_t;

  typedef struct packed {
    logic hs;
    logic vs;
    logic cs;
    logic hblank;
    logic vblank;
    logic osd_window;
    logic osd_pixel;
    rgb_t rgb;
  } video_in_t;

  typedef struct packed {
    logic hs;
    logic vs;
    logic cs;
    rgb_t rgb;
  } video_out_t;

  typedef struct packed {
    logic                    req;
    logic                    we;
    logic                    clut_sel;           // Palette instead of frame
    logic [FRAME_ADDR_W-1:0] addr;
    logic [WORD_W-1:0]       wdata;
  } host_req_t;

  typedef struct packed {
    logic                    en;
    logic                    we;
    logic [FRAME_ADDR_W-1:0] addr;
    logic [WORD_W-1:0]       wdata;
  } mem_req_t;

  // RGB565 to 888, top bits repeated into the low bits
  function automatic rgb_t rgb565_expand(input frame_word_u w);
    rgb_t c;
    c.r = {w.rgb565.red, w.rgb565.red[4:2]};
    c.g = {w.rgb565.green, w.rgb565.green[5:4]};
    c.b = {w.rgb565.blue, w.rgb565.blue[4:2]};
    return c;
  endfunction

endpackage

`default_nettype wire

/* verilog/rtg_frame_ram.sv */
`default_nettype none

module rtg_frame_ram
  import rtg_pkg::*;
(
  input  wire logic              CLK_114,
  input  wire mem_req_t          mem,      // From arbiter
  output logic      [WORD_W-1:0] rdata     // Valid 1 cycle after read
);

  ////////////////////////////////////////////////////////////
  // Storage
  ////////////////////////////////////////////////////////////
  logic [WORD_W-1:0] ram [FRAME_DEPTH];

  // Single port, write has priority over read
  always_ff @(posedge CLK_114) begin
    if (mem.en) begin
      if (mem.we) begin
        ram[mem.addr] <= mem.wdata;        // Host write
      end else begin
        rdata <= ram[mem.addr];            // Fetch read
      end
    end
  end

endmodule

`default_nettype wire

/* verilog/rtg_mem_arbiter.sv */
`default_nettype none

module rtg_mem_arbiter
  import rtg_pkg::*;
(
  input  wire logic                    CLK_114,
  input  wire logic                    rst,
  // Stream fetcher side
  input  wire logic                    fetch_req,
  input  wire logic [FRAME_ADDR_W-1:0] fetch_addr,
  output logic                         fetch_grant,
  output logic                         fill,
  output logic      [WORD_W-1:0]       fill_data,
  // Host side
  input  wire host_req_t               host,
  output logic                         host_ack,
  output logic                         clut_wr,
  output logic      [CLUT_IDX_W-1:0]   clut_idx,
  output rgb_t                         clut_data,
  // Frame memory
  output mem_req_t                     mem,
  input  wire logic [WORD_W-1:0]       rdata
);

  logic host_frame;     // Host wants the frame memory
  logic host_grant;     // Host gets it this cycle
  logic clut_ack_q;     // CLUT write ack, one cycle after req
  logic rd_pend;        // Fetch read in flight

  ////////////////////////////////////////////////////////////
  // Grant
  ////////////////////////////////////////////////////////////
  assign fetch_grant = fetch_req;                    // Fetch wins any tie
  assign host_frame  = host.req & ~host.clut_sel;
  assign host_grant  = host_frame & ~fetch_req;      // First free cycle

  always_comb begin
    mem.en    = fetch_req | (host_grant & host.we);  // Host reads dropped
    mem.we    = ~fetch_req & host.we;
    mem.addr  = fetch_req ? fetch_addr : host.addr;
    mem.wdata = host.wdata;
  end

  ////////////////////////////////////////////////////////////
  // Read return and CLUT acknowledge
  ////////////////////////////////////////////////////////////
  always_ff @(posedge CLK_114) begin
    if (rst) begin
      rd_pend    <= 1'b0;
      clut_ack_q <= 1'b0;
    end else begin
      rd_pend    <= fetch_req;                       // RAM answers next cycle
      clut_ack_q <= host.req & host.clut_sel & ~clut_ack_q;
    end
  end

  assign fill      = rd_pend;
  assign fill_data = rdata;

  // Host fields are held until ack, so write straight from them
  assign clut_wr   = clut_ack_q & host.we;
  assign clut_idx  = host.addr[CLUT_IDX_W-1:0];      // Low address bits
  assign clut_data = rgb565_expand(frame_word_u'(host.wdata));

  assign host_ack  = host_grant | clut_ack_q;        // Single ack point

endmodule

`default_nettype wire

/* verilog/rtg_stream_fetch.sv */
`default_nettype none

module rtg_stream_fetch
  import rtg_pkg::*;
(
  input  wire logic                    CLK_114,
  input  wire logic                    rst,
  input  wire rtg_cfg_t                cfg,
  input  wire logic                    vblank,
  // Arbiter side
  output logic                         fetch_req,
  output logic      [FRAME_ADDR_W-1:0] fetch_addr,
  input  wire logic                    fetch_grant,
  input  wire logic                    fill,
  input  wire logic [WORD_W-1:0]       fill_data,
  // Display side
  input  wire logic                    pixel_pull,
  output frame_word_u                  fifo_word     // First-word fall-through
);

  logic                    clear;                    // Restart the stream
  logic [FRAME_ADDR_W-1:0] base_full;
  logic [FRAME_ADDR_W-1:0] rd_addr;                  // Next frame word
  logic [CNT_W-1:0]        wr_ptr;
  logic [CNT_W-1:0]        rd_ptr;
  logic [CNT_W-1:0]        level;                    // Words in FIFO
  logic [CNT_W-1:0]        in_flight;                // Granted, not yet filled
  logic [CNT_W-1:0]        burst_left;
  logic [CNT_W:0]          committed;                // Level plus in flight
  logic                    granted;
  logic                    empty;
  logic [WORD_W-1:0]       fifo_mem [FIFO_DEPTH];
  logic [WORD_W-1:0]       last_word;                // Shown when empty

  assign clear      = vblank | ~cfg.ena;
  assign base_full  = {cfg.base_addr, {BASE_ALIGN{1'b0}}};
  assign granted    = fetch_req & fetch_grant;
  assign level      = wr_ptr - rd_ptr;
  assign empty      = (wr_ptr == rd_ptr);
  assign committed  = {1'b0, level} + {1'b0, in_flight};
  assign fetch_addr = rd_addr;

  ////////////////////////////////////////////////////////////
  // Address, bursts and pointers
  ////////////////////////////////////////////////////////////
  always_ff @(posedge CLK_114) begin
    if (rst || clear) begin
      rd_addr    <= base_full;                       // Top of frame
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      in_flight  <= '0;
      burst_left <= '0;
      fetch_req  <= 1'b0;
    end else begin
      if (granted) begin
        rd_addr <= rd_addr + 1'b1;                   // Wraps at memory size
      end
      if (fetch_req) begin
        if (fetch_grant) begin
          burst_left <= burst_left - 1'b1;
          if (burst_left == CNT_W'(1)) begin
            fetch_req <= 1'b0;                       // Burst done
          end
        end
      end else if (committed <= FIFO_DEPTH - BURST_LEN) begin
        fetch_req  <= 1'b1;                          // Room for a burst
        burst_left <= CNT_W'(BURST_LEN);
      end
      unique case ({granted, fill})
        2'b10:   in_flight <= in_flight + 1'b1;
        2'b01:   in_flight <= in_flight - 1'b1;
        default: in_flight <= in_flight;
      endcase
      if (fill) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pixel_pull && !empty) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // FIFO storage
  ////////////////////////////////////////////////////////////
  always_ff @(posedge CLK_114) begin
    if (fill && !clear) begin
      fifo_mem[wr_ptr[FIFO_AW-1:0]] <= fill_data;    // Lands 1 cycle after grant
    end
    if (pixel_pull && !empty) begin
      last_word <= fifo_mem[rd_ptr[FIFO_AW-1:0]];
    end
  end

  assign fifo_word = empty ? frame_word_u'(last_word)
                           : frame_word_u'(fifo_mem[rd_ptr[FIFO_AW-1:0]]);

endmodule

`default_nettype wire

/* verilog/rtg_pixel_timing.sv */
`default_nettype none

module rtg_pixel_timing
  import rtg_pkg::*;
(
  input  wire logic     CLK_114,
  input  wire logic     rst,
  input  wire rtg_cfg_t cfg,
  input  wire logic     hs,
  input  wire logic     hblank,
  input  wire logic     vblank,
  output logic          pixel_pull,    // Take next word from FIFO
  output logic          byte_sel,      // High CLUT index
  output logic          rtg_blank
);

  logic [PIX_CNT_W-1:0] pix_cnt;       // Clocks since last pull
  logic [VB_CNT_W-1:0]  vb_cnt;        // Lines since vblank fell
  logic                 rtg_vblank;    // Stretched vblank
  logic                 blank_d;
  logic                 sel_raw;
  logic                 hs_d;
  logic                 hs_rise;

  assign rtg_blank = rtg_vblank | hblank;
  assign hs_rise   = hs & ~hs_d;

  // Fetch strobe, ext lets the last pixel run one clock into blank
  assign pixel_pull = cfg.ena & (pix_cnt == cfg.pixel_width)
                    & (~rtg_blank | (cfg.ext & ~blank_d));

  ////////////////////////////////////////////////////////////
  // Pixel clock and byte select
  ////////////////////////////////////////////////////////////
  always_ff @(posedge CLK_114) begin
    if (rst) begin
      pix_cnt  <= '0;
      sel_raw  <= 1'b0;
      byte_sel <= 1'b0;
      blank_d  <= 1'b1;                              // Counts as blank out of reset
      hs_d     <= 1'b0;
    end else begin
      blank_d  <= rtg_blank;
      hs_d     <= hs;
      byte_sel <= sel_raw & ~pixel_pull;             // One cycle late, low on a new word
      if (pix_cnt == {1'b0, cfg.pixel_width[PIX_CNT_W-1:1]}) begin
        sel_raw <= 1'b1;                             // Halfway through pixel
      end
      if (rtg_blank || pixel_pull) begin
        pix_cnt <= '0;
        sel_raw <= 1'b0;
      end else begin
        pix_cnt <= pix_cnt + 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Extended vertical blank
  ////////////////////////////////////////////////////////////
  always_ff @(posedge CLK_114) begin
    if (rst) begin
      rtg_vblank <= 1'b1;
      vb_cnt     <= '0;
    end else if (vblank) begin
      rtg_vblank <= 1'b1;                            // Restart line count
      vb_cnt     <= '0;
    end else if (vb_cnt == cfg.vb_end) begin
      rtg_vblank <= 1'b0;                            // Enough extra lines
    end else if (hs_rise) begin
      vb_cnt <= vb_cnt + 1'b1;
    end
  end

endmodule

`default_nettype wire

/* verilog/rtg_pixel_out.sv */
`default_nettype none

module rtg_pixel_out
  import rtg_pkg::*;
(
  input  wire logic                  CLK_114,
  input  wire logic                  rst,
  input  wire rtg_cfg_t              cfg,
  input  wire video_in_t             video_in,
  input  wire frame_word_u           fifo_word,
  input  wire logic                  byte_sel,
  input  wire logic                  rtg_blank,
  input  wire logic                  clut_wr,
  input  wire logic [CLUT_IDX_W-1:0] clut_idx,
  input  wire rgb_t                  clut_data,
  output video_out_t                 video_out
);

  rgb_t                  clut_mem [CLUT_DEPTH];      // Palette
  logic [CLUT_IDX_W-1:0] rd_idx;
  rgb_t                  clut_col;
  rgb_t                  direct_col;                 // Expanded RGB565
  rgb_t                  rtg_col;
  rgb_t                  mix_col;                    // Chipset or RTG
  rgb_t                  osd_col;
  logic [1:0]            osd_r;
  logic [1:0]            osd_g;
  logic [1:0]            osd_b;

  ////////////////////////////////////////////////////////////
  // Palette, written by host only
  ////////////////////////////////////////////////////////////
  always_ff @(posedge CLK_114) begin
    if (clut_wr) begin
      clut_mem[clut_idx] <= clut_data;
    end
  end

  assign rd_idx   = byte_sel ? fifo_word.clut.hi_idx : fifo_word.clut.lo_idx;
  assign clut_col = clut_mem[rd_idx];                // Async read

  ////////////////////////////////////////////////////////////
  // Colour select and OSD overlay
  ////////////////////////////////////////////////////////////
  assign direct_col = rgb565_expand(fifo_word);
  assign rtg_col    = cfg.clut_mode ? clut_col : direct_col;
  assign mix_col    = (cfg.ena && !rtg_blank) ? rtg_col : video_in.rgb;

  // Bluish OSD background, white text
  assign osd_r = video_in.osd_pixel ? 2'b11 : 2'b00;
  assign osd_g = video_in.osd_pixel ? 2'b11 : 2'b00;
  assign osd_b = video_in.osd_pixel ? 2'b11 : 2'b10;

  always_comb begin
    osd_col = mix_col;
    if (video_in.osd_window) begin
      osd_col.r = {osd_r, mix_col.r[COLOR_W-1:2]};   // Dimmed underneath
      osd_col.g = {osd_g, mix_col.g[COLOR_W-1:2]};
      osd_col.b = {osd_b, mix_col.b[COLOR_W-1:2]};
    end
  end

  ////////////////////////////////////////////////////////////
  // Output register
  ////////////////////////////////////////////////////////////
  always_ff @(posedge CLK_114) begin
    if (rst) begin
      video_out <= '0;
    end else begin
      video_out.hs  <= video_in.hs;
      video_out.vs  <= video_in.vs;
      video_out.cs  <= video_in.cs;
      video_out.rgb <= osd_col;                      // Syncs and colour aligned
    end
  end

endmodule

`default_nettype wire

/* verilog/rtg_display_top.sv */
`default_nettype none

module rtg_display_top
  import rtg_pkg::*;
(
  input  wire logic      CLK_114,
  input  wire logic      rst,
  input  wire rtg_cfg_t  cfg,          // Static setup
  input  wire video_in_t video_in,     // Chipset video
  input  wire host_req_t host,
  output logic           host_ack,
  output video_out_t     video_out
);

  ////////////////////////////////////////////////////////////
  // Interconnect
  ////////////////////////////////////////////////////////////
  logic                    fetch_req;
  logic [FRAME_ADDR_W-1:0] fetch_addr;
  logic                    fetch_grant;
  logic                    fill;
  logic [WORD_W-1:0]       fill_data;
  mem_req_t                mem;
  logic [WORD_W-1:0]       rdata;
  logic                    clut_wr;
  logic [CLUT_IDX_W-1:0]   clut_idx;
  rgb_t                    clut_data;
  logic                    pixel_pull;
  frame_word_u             fifo_word;
  logic                    byte_sel;
  logic                    rtg_blank;

  rtg_frame_ram rtg_frame_ram_inst (
    .CLK_114 (CLK_114),
    .mem     (mem),
    .rdata   (rdata)
  );

  rtg_mem_arbiter rtg_mem_arbiter_inst (
    .CLK_114     (CLK_114),
    .rst         (rst),
    .fetch_req   (fetch_req),
    .fetch_addr  (fetch_addr),
    .fetch_grant (fetch_grant),
    .fill        (fill),
    .fill_data   (fill_data),
    .host        (host),
    .host_ack    (host_ack),
    .clut_wr     (clut_wr),
    .clut_idx    (clut_idx),
    .clut_data   (clut_data),
    .mem         (mem),
    .rdata       (rdata)
  );

  rtg_stream_fetch rtg_stream_fetch_inst (
    .CLK_114     (CLK_114),
    .rst         (rst),
    .cfg         (cfg),
    .vblank      (video_in.vblank),  // Restart at each frame
    .fetch_req   (fetch_req),
    .fetch_addr  (fetch_addr),
    .fetch_grant (fetch_grant),
    .fill        (fill),
    .fill_data   (fill_data),
    .pixel_pull  (pixel_pull),
    .fifo_word   (fifo_word)
  );

  rtg_pixel_timing rtg_pixel_timing_inst (
    .CLK_114    (CLK_114),
    .rst        (rst),
    .cfg        (cfg),
    .hs         (video_in.hs),
    .hblank     (video_in.hblank),
    .vblank     (video_in.vblank),
    .pixel_pull (pixel_pull),
    .byte_sel   (byte_sel),
    .rtg_blank  (rtg_blank)
  );

  rtg_pixel_out rtg_pixel_out_inst (
    .CLK_114   (CLK_114),
    .rst       (rst),
    .cfg       (cfg),
    .video_in  (video_in),
    .fifo_word (fifo_word),
    .byte_sel  (byte_sel),
    .rtg_blank (rtg_blank),
    .clut_wr   (clut_wr),
    .clut_idx  (clut_idx),
    .clut_data (clut_data),
    .video_out (video_out)
  );

endmodule

`default_nettype wire

/* verif/tb_clock_gen.sv */
`default_nettype none

module tb_clock_gen (
  output logic clk,
  output logic rst
);

  timeunit 1ns;
  timeprecision 100ps;

  localparam realtime HALF_PERIOD = 2ns;             // 4 ns period
  localparam int      RESET_CYCLES = 8;

  initial begin
    clk = 1'b0;
    forever #(HALF_PERIOD) clk = ~clk;
  end

  initial begin
    rst = 1'b1;                                      // Sync reset, active high
    repeat (RESET_CYCLES) @(posedge clk);
    rst <= 1'b0;
  end

endmodule

`default_nettype wire

/* verif/rtg_display_tb.sv */
`default_nettype none

module rtg_display_tb
  import rtg_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  ////////////////////////////////////////////////////////////
  // Raster geometry and run length
  ////////////////////////////////////////////////////////////
  localparam int LINE_LEN    = 48;                   // 32 active, 16 hblank
  localparam int ACT_W       = 32;
  localparam int VB_LINES    = 2;
  localparam int ACT_LINES   = 6;
  localparam int FRAME_CYC   = LINE_LEN * (VB_LINES + ACT_LINES);
  localparam int N_FRAMES    = 7;
  localparam int N_WORDS     = 96;                   // Words per test frame region
  localparam int N_WRITES    = 2 * N_WORDS + CLUT_DEPTH;
  localparam int TOTAL_CYC   = 16 + N_FRAMES * FRAME_CYC + N_WRITES * 8;
  localparam int WATCHDOG_NS = 2 * TOTAL_CYC * 4;    // Twice the raster length
  localparam rgb_t CHIP_COL = '{r: 8'h12, g: 8'h34, b: 8'h56};

  logic       clk;
  logic       rst;
  rtg_cfg_t   cfg;
  video_in_t  video_in;
  host_req_t  host;
  logic       host_ack;
  video_out_t video_out;

  logic [WORD_W-1:0] frame_model [FRAME_DEPTH];      // Expected memory
  rgb_t              clut_model [CLUT_DEPTH];
  rgb_t              got [$];                        // Distinct RTG colours
  int                err_cnt;
  int                pass_cnt;
  int                fail_cnt;
  int                hs_count;
  string             test_name;
  logic              collect;
  logic              seen_rtg;
  logic              osd_random;
  logic              last_hs;
  logic              prev_valid;
  video_in_t         prev_in;
  rtg_cfg_t          prev_cfg;

  tb_clock_gen tb_clock_gen_inst (.clk(clk), .rst(rst));

  rtg_display_top rtg_display_top_inst (
    .CLK_114   (clk),
    .rst       (rst),
    .cfg       (cfg),
    .video_in  (video_in),
    .host      (host),
    .host_ack  (host_ack),
    .video_out (video_out)
  );

  // 5/6 bit field to 8 bits, top bits fill the bottom
  function automatic rgb_t expand565(input logic [15:0] w);
    rgb_t c;
    c.r = (8'(w[15:11]) << 3) | (8'(w[15:11]) >> 2);
    c.g = (8'(w[10:5]) << 2) | (8'(w[10:5]) >> 4);
    c.b = (8'(w[4:0]) << 3) | (8'(w[4:0]) >> 2);
    return c;
  endfunction

  // Reference for one output sample
  function automatic video_out_t expected_video(input rtg_cfg_t c, input video_in_t v,
                                                input logic rtg_on, input rgb_t rtg_col);
    video_out_t o;
    rgb_t       u;
    logic [1:0] top_r;
    logic [1:0] top_g;
    logic [1:0] top_b;
    u = (c.ena && rtg_on) ? rtg_col : v.rgb;
    top_r = v.osd_pixel ? 2'b11 : 2'b00;
    top_g = v.osd_pixel ? 2'b11 : 2'b00;
    top_b = v.osd_pixel ? 2'b11 : 2'b10;             // Blue tint behind text
    o.hs = v.hs;
    o.vs = v.vs;
    o.cs = v.cs;
    o.rgb = u;
    if (v.osd_window) begin
      o.rgb.r = {top_r, u.r[7:2]};
      o.rgb.g = {top_g, u.g[7:2]};
      o.rgb.b = {top_b, u.b[7:2]};
    end
    return o;
  endfunction

  // n-th distinct colour of the RTG stream
  function automatic rgb_t stream_colour(input rtg_cfg_t c, input int n);
    int                idx;
    logic [WORD_W-1:0] w;
    idx = c.clut_mode ? n / 2 : n;
    w = frame_model[({c.base_addr, 4'b0} + idx) % FRAME_DEPTH];
    if (!c.clut_mode) return expand565(w);
    return clut_model[(n % 2) ? w[15:8] : w[7:0]];   // Low byte first
  endfunction

  ////////////////////////////////////////////////////////////
  // Comparison process
  ////////////////////////////////////////////////////////////
  always @(posedge clk) begin
    video_out_t exp;
    if (!rst && prev_valid) begin
      assert ({video_out.hs, video_out.vs, video_out.cs} == {prev_in.hs, prev_in.vs, prev_in.cs})
      else begin
        $display("CHECK FAILED %s syncs expected %b actual %b", test_name,
                 {prev_in.hs, prev_in.vs, prev_in.cs},
                 {video_out.hs, video_out.vs, video_out.cs});
        err_cnt++;
      end
      if (!prev_cfg.ena) begin
        exp = expected_video(prev_cfg, prev_in, 1'b0, '0);
        assert (video_out.rgb == exp.rgb)
        else begin
          $display("CHECK FAILED %s colour expected %h actual %h", test_name, exp.rgb,
                   video_out.rgb);
          err_cnt++;
        end
      end else if (collect) begin
        if (prev_in.vblank) begin                    // Restart line count
          hs_count = 0;
          seen_rtg = 1'b0;
        end else if (video_out.rgb != prev_in.rgb) begin
          seen_rtg = 1'b1;
          if (got.size() == 0 || got[$] != video_out.rgb) got.push_back(video_out.rgb);
        end else if (!seen_rtg && video_out.hs && !last_hs) begin
          hs_count++;
        end
      end
    end
    last_hs = video_out.hs;
    prev_in = video_in;
    prev_cfg = cfg;
    prev_valid = !rst;
  end

  ////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////
  task automatic run_frame();
    for (int line = 0; line < VB_LINES + ACT_LINES; line++) begin
      for (int x = 0; x < LINE_LEN; x++) begin
        @(posedge clk);
        video_in.hs <= (x >= 36 && x < 40);
        video_in.vs <= (line == 0);
        video_in.cs <= (x >= 36 && x < 40) ^ (line == 0);
        video_in.hblank <= (x >= ACT_W);
        video_in.vblank <= (line < VB_LINES);
        video_in.osd_window <= osd_random ? 1'($urandom()) : 1'b0;
        video_in.osd_pixel <= osd_random ? 1'($urandom()) : 1'b0;
        video_in.rgb <= osd_random ? rgb_t'($urandom()) : CHIP_COL;
      end
    end
  endtask

  task automatic host_write(input logic clut, input logic [11:0] addr,
                            input logic [15:0] data);
    int   waited;
    logic acked;
    acked = 1'b0;
    waited = 0;
    @(posedge clk);
    host.req <= 1'b1;
    host.we <= 1'b1;
    host.clut_sel <= clut;
    host.addr <= addr;
    host.wdata <= data;
    while (!acked && waited < 64) begin
      @(negedge clk);                                // Ack is stable here
      acked = host_ack;
      waited++;
    end
    @(posedge clk);
    host.req <= 1'b0;
    assert (acked)
    else begin
      $display("%s: host write to %h got no acknowledge in 64 cycles", test_name, addr);
      err_cnt++;
    end
    if (clut) clut_model[addr[7:0]] = expand565(data);
    else frame_model[addr] = data;
  endtask

  // Neighbouring words and neighbouring CLUT indices differ
  task automatic fill_region(input logic [11:0] base, input logic clut);
    logic [15:0] w;
    logic [15:0] prev;
    prev = frame_model[base - 1];
    for (int i = 0; i < N_WORDS; i++) begin
      do begin
        w = 16'($urandom());
      end while (w == prev || (clut && (w[7:0] == w[15:8] || w[7:0] == prev[15:8])));
      host_write(1'b0, base + 12'(i), w);
      prev = w;
    end
  endtask

  task automatic set_cfg(input logic ena, input logic clut, input logic [2:0] pw,
                         input logic [4:0] vb, input logic [7:0] base);
    @(posedge clk);
    cfg <= '{ena: ena, clut_mode: clut, ext: 1'b0, pixel_width: pw, vb_end: vb,
             base_addr: base};
  endtask

  task automatic check_stream(input int min_len);
    rgb_t exp;
    logic ok;
    assert (got.size() >= min_len)
    else begin
      $display("%s: only %0d RTG colours seen, at least %0d wanted", test_name,
               got.size(), min_len);
      err_cnt++;
    end
    foreach (got[i]) begin
      exp = stream_colour(cfg, i);
      ok = (got[i] === exp);
      assert (ok)
      else begin
        $display("CHECK FAILED %s colour %0d expected %h actual %h", test_name, i, exp, got[i]);
        err_cnt++;
      end
      if (!ok) break;
    end
  endtask

  task automatic end_test(input int errs_before);
    if (err_cnt == errs_before) pass_cnt++;
    else fail_cnt++;
    $display("test %s: %s", test_name, (err_cnt == errs_before) ? "pass" : "fail");
  endtask

  task automatic start_frame_collect();
    @(posedge clk);
    got.delete();
    collect <= 1'b1;
    run_frame();
    @(posedge clk);
    collect <= 1'b0;
  endtask

  // Watchdog
  initial begin
    #(WATCHDOG_NS * 1ns);
    $display("Watchdog expired, the run took longer than %0d ns", WATCHDOG_NS);
    $display("Test FAILED");
    $finish;
  end

  initial begin
    int e;
    void'($urandom(20));
    cfg = '0;
    video_in = '0;
    video_in.rgb = CHIP_COL;                         // Nonzero during reset
    host = '0;
    err_cnt = 0;
    pass_cnt = 0;
    fail_cnt = 0;
    collect = 1'b0;
    osd_random = 1'b0;
    seen_rtg = 1'b0;
    hs_count = 0;
    prev_valid = 1'b0;
    last_hs = 1'b0;
    prev_in = '0;
    prev_cfg = '0;

    test_name = "reset_passthrough";
    e = err_cnt;
    @(negedge clk);
    while (rst) @(negedge clk);
    assert (video_out == '0 && host_ack == 1'b0)
    else begin
      $display("CHECK FAILED %s outputs expected 0 actual %h", test_name, video_out);
      err_cnt++;
    end
    run_frame();
    end_test(e);

    test_name = "rgb565_stream";
    e = err_cnt;
    fill_region(12'h100, 1'b0);
    set_cfg(1'b1, 1'b0, 3'd1, 5'd2, 8'h10);
    start_frame_collect();
    check_stream(40);
    end_test(e);

    test_name = "clut_mode";
    e = err_cnt;
    set_cfg(1'b0, 1'b0, 3'd1, 5'd2, 8'h10);
    for (int i = 0; i < CLUT_DEPTH; i++) begin
      host_write(1'b1, 12'(i), {8'(i), 8'(i) ^ 8'h5A});  // Distinct per entry
    end
    fill_region(12'h200, 1'b1);
    set_cfg(1'b1, 1'b1, 3'd3, 5'd2, 8'h20);
    start_frame_collect();
    check_stream(36);
    end_test(e);

    test_name = "extended_vblank";
    e = err_cnt;
    set_cfg(1'b1, 1'b0, 3'd1, 5'd3, 8'h10);
    start_frame_collect();
    assert (seen_rtg && hs_count == 3)
    else begin
      $display("CHECK FAILED %s hs edges expected 3 actual %0d", test_name, hs_count);
      err_cnt++;
    end
    end_test(e);

    test_name = "osd_overlay";
    e = err_cnt;
    set_cfg(1'b0, 1'b0, 3'd1, 5'd2, 8'h10);
    osd_random = 1'b1;
    run_frame();
    osd_random = 1'b0;
    end_test(e);

    test_name = "host_under_fetch";
    e = err_cnt;
    set_cfg(1'b1, 1'b0, 3'd1, 5'd2, 8'h10);
    fork
      run_frame();
      begin
        repeat (3 * LINE_LEN) @(posedge clk);        // Into the active lines
        fill_region(12'h100, 1'b0);
      end
    join
    start_frame_collect();
    check_stream(40);
    end_test(e);

    $display("tests passed: %0d failed: %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0 && err_cnt == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* filelist.f */
verilog/rtg_pkg.sv
verilog/rtg_frame_ram.sv
verilog/rtg_mem_arbiter.sv
verilog/rtg_stream_fetch.sv
verilog/rtg_pixel_timing.sv
verilog/rtg_pixel_out.sv
verilog/rtg_display_top.sv
verif/tb_clock_gen.sv
verif/rtg_display_tb.sv
